// File: files.f
rtl/vidPkg.sv
rtl/vidTiming.sv
rtl/vramSequencer.sv
rtl/pixelSerializer.sv
rtl/vidGen.sv
sim/vramModel.sv
sim/tbVidGen.sv

// File: rtl/pixelSerializer.sv
// serializes fetched bytes into RGBI pixels in 4bpp or 2bpp gray mode, with blanking
`default_nettype none

module pixelSerializer (
    input  wire logic           pixClk,
    input  wire logic           nReset,
    input  wire vidPkg::hCountT hCount,
    input  wire logic           hActive,
    input  wire logic           vActive,
    input  wire vidPkg::byteT   fetchByte,
    input  wire logic           grayMode,
    input  wire logic           blank,
    output vidPkg::rgbiT        vidOut
);

    logic           inWindow;
    vidPkg::rgbiT   pix;
    logic [1:0]     grayPair;

    // visible window trails the fetch window by fetchLag clocks
    // so it runs a little past the end of hActive
    assign inWindow = vActive &&
                      (hActive ? (hCount >= vidPkg::fetchLag) :
                                 (hCount < vidPkg::hVis + vidPkg::fetchLag));

    // a byte is current from phase 2 through phase 1 of the next group
    always_comb begin
        case (hCount[1:0])
            2'd2: grayPair = fetchByte[7:6];
            2'd3: grayPair = fetchByte[5:4];
            2'd0: grayPair = fetchByte[3:2];
            default: grayPair = fetchByte[1:0];
        endcase
        if (grayMode) begin
            // high bit drives R, G and B, low bit is intensity
            pix = {grayPair[1], grayPair[1], grayPair[1], grayPair[0]};
        end else if (hCount[1]) begin
            // upper nibble for the first two clocks
            pix = fetchByte[7:4];
        end else begin
            pix = fetchByte[3:0];
        end
    end

    // one clock of output register
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidOut <= '0;
        end else if (!inWindow || blank) begin
            vidOut <= '0;
        end else begin
            vidOut <= pix;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vidGen.sv
// video generator top level joining timing, vram sequencer and pixel serializer
`default_nettype none

module vidGen (
    input  wire logic             pixClk,
    input  wire logic             nReset,
    // cpu bus
    input  wire logic             nCpuCe,
    input  wire logic             nCpuDs,
    input  wire logic             cpuRnW,
    input  wire vidPkg::cpuAddrT  cpuAddr,
    input  wire vidPkg::byteT     cpuWrData,
    output wire vidPkg::byteT     cpuRdData,
    output wire logic             cpuRdEn,
    output wire logic             nCpuDsAck,
    // vram bus
    output wire vidPkg::vramAddrT vramAddr,
    output wire vidPkg::byteT     vramWrData,
    output wire logic             vramDataOe,
    output wire logic             nVramCe0,
    output wire logic             nVramCe1,
    output wire logic             nVramRd,
    output wire logic             nVramWr,
    input  wire vidPkg::byteT     vramRdData,
    // video out
    output wire vidPkg::rgbiT     vidOut,
    output wire logic             vidH,
    output wire logic             vidV
);

    wire vidPkg::hCountT hCount;
    wire logic           hActive;
    wire logic           vActive;
    wire vidPkg::byteT   fetchByte;
    wire logic           grayMode;
    wire logic           blank;

    // the line counter only feeds the sync and window decode inside timing
    vidTiming uTiming (
        .pixClk  (pixClk),
        .nReset  (nReset),
        .hCount  (hCount),
        .vCount  (),
        .hActive (hActive),
        .vActive (vActive),
        .vidH    (vidH),
        .vidV    (vidV)
    );

    vramSequencer uSeq (
        .pixClk     (pixClk),
        .nReset     (nReset),
        .hCount     (hCount),
        .hActive    (hActive),
        .vActive    (vActive),
        .nCpuCe     (nCpuCe),
        .nCpuDs     (nCpuDs),
        .cpuRnW     (cpuRnW),
        .cpuAddr    (cpuAddr),
        .cpuWrData  (cpuWrData),
        .vramRdData (vramRdData),
        .cpuRdData  (cpuRdData),
        .cpuRdEn    (cpuRdEn),
        .nCpuDsAck  (nCpuDsAck),
        .vramAddr   (vramAddr),
        .vramWrData (vramWrData),
        .vramDataOe (vramDataOe),
        .nVramCe0   (nVramCe0),
        .nVramCe1   (nVramCe1),
        .nVramRd    (nVramRd),
        .nVramWr    (nVramWr),
        .fetchByte  (fetchByte),
        .grayMode   (grayMode),
        .blank      (blank)
    );

    pixelSerializer uSer (
        .pixClk    (pixClk),
        .nReset    (nReset),
        .hCount    (hCount),
        .hActive   (hActive),
        .vActive   (vActive),
        .fetchByte (fetchByte),
        .grayMode  (grayMode),
        .blank     (blank),
        .vidOut    (vidOut)
    );

endmodule

`default_nettype wire

// File: rtl/vidPkg.sv
// video timing constants, control register layout, shared vector types and sequencer states
`default_nettype none

package vidPkg;

    // pixel and line counters
    typedef logic [9:0] hCountT;
    typedef logic [8:0] vCountT;

    // cpu address and fetch address share one width
    typedef logic [15:0] cpuAddrT;
    // one vram chip is 32K deep
    typedef logic [14:0] vramAddrT;
    typedef logic [7:0] byteT;
    // one RGBI pixel, bit 3 is red and bit 0 is intensity
    typedef logic [3:0] rgbiT;

    // 640x400 at 70 Hz from a 25.175 MHz pixel clock
    localparam hCountT hVis   = 10'd640;
    localparam hCountT hFront = 10'd16;
    localparam hCountT hSync  = 10'd96;
    localparam hCountT hBack  = 10'd48;
    localparam hCountT hTotal = hVis + hFront + hSync + hBack;

    // vertical timing in lines
    localparam vCountT vVis   = 9'd400;
    localparam vCountT vFront = 9'd12;
    localparam vCountT vSync  = 9'd2;
    localparam vCountT vBack  = 9'd35;
    localparam vCountT vTotal = vVis + vFront + vSync + vBack;

    // clocks from a fetch slot to the first pixel of that byte
    // hsync is moved by the same amount so the picture stays centred
    localparam hCountT fetchLag = 10'd2;

    // control register sits at the top of the cpu window
    localparam cpuAddrT regAddr = 16'hFFFF;

    // control register bit positions
    // bits 1, 2, 6 and 7 read back as ones
    localparam int regBlankBit  = 0;
    localparam int regGrayBit   = 3;
    localparam int regHBlankBit = 4;
    localparam int regVBlankBit = 5;

    // vram sequencer states
    // seqCpuRead is the single clock with the read strobe out
    // seqAckHold keeps the acknowledge until the cpu drops its data strobe
    typedef enum logic [1:0] {
        seqIdle,
        seqCpuRead,
        seqAckHold
    } seqStateT;

endpackage

`default_nettype wire

// File: rtl/vidTiming.sv
// pixel and line counters, registered sync outputs and active window decode
`default_nettype none

module vidTiming (
    input  wire logic         pixClk,
    input  wire logic         nReset,
    output vidPkg::hCountT    hCount,
    output vidPkg::vCountT    vCount,
    output logic              hActive,
    output logic              vActive,
    output logic              vidH,
    output logic              vidV
);

    // last pixel of the line
    logic hWrap;
    // last line of the frame
    logic vWrap;

    assign hWrap = (hCount == vidPkg::hTotal - 10'd1);
    assign vWrap = (vCount == vidPkg::vTotal - 9'd1);

    // pixel counter steps every clock, line counter on each wrap
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            if (hWrap) begin
                hCount <= '0;
                if (vWrap) begin
                    vCount <= '0;
                end else begin
                    vCount <= vCount + 9'd1;
                end
            end else begin
                hCount <= hCount + 10'd1;
            end
        end
    end

    // active window decoded here once
    // sequencer and serializer both take these flags
    assign hActive = (hCount < vidPkg::hVis);
    assign vActive = (vCount < vidPkg::vVis);

    // hsync is active low
    // pulse start is pushed out by fetchLag to match the pixel pipeline,
    // and the output register adds one more clock on top of that
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidH <= 1'b1;
        end else begin
            if ((hCount >= vidPkg::hVis + vidPkg::hFront + vidPkg::fetchLag) &&
                (hCount < vidPkg::hVis + vidPkg::hFront + vidPkg::fetchLag + vidPkg::hSync)) begin
                vidH <= 1'b0;
            end else begin
                vidH <= 1'b1;
            end
        end
    end

    // vsync is active high, two lines after the front porch
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidV <= 1'b0;
        end else begin
            if ((vCount >= vidPkg::vVis + vidPkg::vFront) &&
                (vCount < vidPkg::vVis + vidPkg::vFront + vidPkg::vSync)) begin
                vidV <= 1'b1;
            end else begin
                vidV <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/vramSequencer.sv
// vram fetch address counter, cpu/video arbitration, control register and cpu acknowledge
`default_nettype none

module vramSequencer (
    input  wire logic           pixClk,
    input  wire logic           nReset,
    input  wire vidPkg::hCountT hCount,
    input  wire logic           hActive,
    input  wire logic           vActive,
    input  wire logic           nCpuCe,
    input  wire logic           nCpuDs,
    input  wire logic           cpuRnW,
    input  wire vidPkg::cpuAddrT cpuAddr,
    input  wire vidPkg::byteT   cpuWrData,
    input  wire vidPkg::byteT   vramRdData,
    output vidPkg::byteT        cpuRdData,
    output logic                cpuRdEn,
    output logic                nCpuDsAck,
    output vidPkg::vramAddrT    vramAddr,
    output vidPkg::byteT        vramWrData,
    output logic                vramDataOe,
    output logic                nVramCe0,
    output logic                nVramCe1,
    output logic                nVramRd,
    output logic                nVramWr,
    output vidPkg::byteT        fetchByte,
    output logic                grayMode,
    output logic                blank
);

    vidPkg::seqStateT state;
    // next byte of the frame to fetch
    vidPkg::cpuAddrT  fetchAddr;
    // a fetch strobe is on the bus this clock
    logic             fetchPending;
    // the cycle being acknowledged is a read
    logic             rdAck;

    logic             fetchSlot;
    logic             cpuReq;
    logic             regHit;
    logic             readOk;
    logic             takeReg;
    logic             takeWrite;
    logic             takeRead;
    logic             ackNow;
    vidPkg::byteT     regRdData;

    // phase 0 of every active group of four belongs to the video fetch
    assign fetchSlot = hActive && vActive && (hCount[1:0] == 2'd0);

    // cpu asks for a cycle with both strobes low
    assign cpuReq = !nCpuCe && !nCpuDs;
    assign regHit = (cpuAddr == vidPkg::regAddr);

    // a read needs two clocks before the next fetch slot
    // during active video only phases 1 and 2 leave room for that,
    // in blanking anything short of the last two clocks of the line will do
    always_comb begin
        if (hActive && vActive) begin
            readOk = (hCount[1:0] == 2'd1) || (hCount[1:0] == 2'd2);
        end else begin
            readOk = (hCount < vidPkg::hTotal - 10'd2);
        end
    end

    // requests are only taken from idle
    // so a held strobe cannot start the same cycle a second time
    assign takeReg   = (state == vidPkg::seqIdle) && cpuReq && !fetchSlot && regHit;
    assign takeWrite = (state == vidPkg::seqIdle) && cpuReq && !fetchSlot && !regHit && !cpuRnW;
    assign takeRead  = (state == vidPkg::seqIdle) && cpuReq && !fetchSlot && !regHit && cpuRnW &&
                       readOk;

    // sequencer state
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            state <= vidPkg::seqIdle;
            rdAck <= 1'b0;
        end else begin
            case (state)
                vidPkg::seqIdle: begin
                    if (takeRead) begin
                        state <= vidPkg::seqCpuRead;
                        rdAck <= 1'b1;
                    end else if (takeReg || takeWrite) begin
                        state <= vidPkg::seqAckHold;
                        rdAck <= cpuRnW;
                    end
                end
                // read data is captured at the end of this clock
                vidPkg::seqCpuRead: begin
                    state <= vidPkg::seqAckHold;
                end
                // wait for the cpu to end its cycle
                vidPkg::seqAckHold: begin
                    if (nCpuDs) begin
                        state <= vidPkg::seqIdle;
                        rdAck <= 1'b0;
                    end
                end
                default: begin
                    state <= vidPkg::seqIdle;
                end
            endcase
        end
    end

    // acknowledge drops as soon as the cpu releases its strobes
    assign ackNow    = (state == vidPkg::seqAckHold) && cpuReq;
    assign nCpuDsAck = !ackNow;
    assign cpuRdEn   = ackNow && rdAck;

    // fetch address walks the frame and restarts during vertical blanking
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            fetchAddr    <= '0;
            fetchPending <= 1'b0;
        end else begin
            fetchPending <= fetchSlot;
            if (fetchSlot) begin
                fetchAddr <= fetchAddr + 16'd1;
            end else if (!vActive) begin
                fetchAddr <= '0;
            end
        end
    end

    // vram strobes for the next clock
    // the bus is idle unless a fetch or a cpu vram cycle claims it
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            nVramCe0   <= 1'b1;
            nVramCe1   <= 1'b1;
            nVramRd    <= 1'b1;
            nVramWr    <= 1'b1;
            vramDataOe <= 1'b0;
        end else begin
            nVramCe0   <= 1'b1;
            nVramCe1   <= 1'b1;
            nVramRd    <= 1'b1;
            nVramWr    <= 1'b1;
            vramDataOe <= 1'b0;
            if (fetchSlot) begin
                // address bit 15 picks the chip
                nVramCe0 <= fetchAddr[15];
                nVramCe1 <= !fetchAddr[15];
                nVramRd  <= 1'b0;
            end else if (takeWrite || takeRead) begin
                nVramCe0   <= cpuAddr[15];
                nVramCe1   <= !cpuAddr[15];
                nVramRd    <= !takeRead;
                // write strobe and data enable last exactly one clock
                nVramWr    <= !takeWrite;
                vramDataOe <= takeWrite;
            end
        end
    end

    // address and data payload
    always_ff @(posedge pixClk) begin
        if (fetchSlot) begin
            vramAddr <= fetchAddr[14:0];
        end else begin
            vramAddr <= cpuAddr[14:0];
        end
        if (takeWrite) begin
            vramWrData <= cpuWrData;
        end
        // video byte lands one clock after its read strobe
        if (fetchPending) begin
            fetchByte <= vramRdData;
        end
        if (takeReg && cpuRnW) begin
            cpuRdData <= regRdData;
        end else if (state == vidPkg::seqCpuRead) begin
            cpuRdData <= vramRdData;
        end
    end

    // control register, written on a register write cycle
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            blank    <= 1'b0;
            grayMode <= 1'b0;
        end else if (takeReg && !cpuRnW) begin
            blank    <= cpuWrData[vidPkg::regBlankBit];
            grayMode <= cpuWrData[vidPkg::regGrayBit];
        end
    end

    // register read value with live blanking status
    always_comb begin
        // unused bits read as ones
        regRdData = 8'hFF;
        regRdData[vidPkg::regBlankBit]  = blank;
        regRdData[vidPkg::regGrayBit]   = grayMode;
        regRdData[vidPkg::regHBlankBit] = !hActive;
        regRdData[vidPkg::regVBlankBit] = !vActive;
    end

endmodule

`default_nettype wire

// File: sim/tbVidGen.sv
// testbench for the video generator: reset, sync timing, control register, vram and pixel tests
`default_nettype none

module tbVidGen;

    // video mode numbers
    localparam int lineClks   = 800;
    localparam int hSyncClks  = 96;
    localparam int hBackClks  = 48;
    localparam int frameLines = 449;
    localparam int vSyncLines = 2;
    // blanking lines between the end of vsync and line 0
    localparam int vBackLines = 35;
    localparam logic [15:0] ctrlAddr = 16'hFFFF;
    // wait limits in clocks
    localparam int ackLimit   = 32;
    localparam int frameLimit = 400000;
    // columns checked on line 0, four per preloaded byte
    localparam int testCols   = 64;

    logic        pixClk;
    logic        nReset;
    logic        nCpuCe;
    logic        nCpuDs;
    logic        cpuRnW;
    logic [15:0] cpuAddr;
    logic [7:0]  cpuWrData;
    logic [7:0]  cpuRdData;
    logic        cpuRdEn;
    logic        nCpuDsAck;
    logic [14:0] vramAddr;
    logic [7:0]  vramWrData;
    logic        vramDataOe;
    logic        nVramCe0;
    logic        nVramCe1;
    logic        nVramRd;
    logic        nVramWr;
    logic [7:0]  vramRdData;
    logic [3:0]  vidOut;
    logic        vidH;
    logic        vidV;

    int          errCount = 0;
    int          testCount = 0;
    int unsigned seed;
    // first bytes of the frame, preloaded into chip 0
    logic [7:0]  frameBytes [16];

    vidGen DUT (
        .pixClk(pixClk), .nReset(nReset),
        .nCpuCe(nCpuCe), .nCpuDs(nCpuDs), .cpuRnW(cpuRnW), .cpuAddr(cpuAddr),
        .cpuWrData(cpuWrData), .cpuRdData(cpuRdData), .cpuRdEn(cpuRdEn),
        .nCpuDsAck(nCpuDsAck),
        .vramAddr(vramAddr), .vramWrData(vramWrData), .vramDataOe(vramDataOe),
        .nVramCe0(nVramCe0), .nVramCe1(nVramCe1), .nVramRd(nVramRd), .nVramWr(nVramWr),
        .vramRdData(vramRdData),
        .vidOut(vidOut), .vidH(vidH), .vidV(vidV)
    );

    vramModel VRAM (
        .pixClk(pixClk), .vramAddr(vramAddr), .vramWrData(vramWrData),
        .vramDataOe(vramDataOe), .nVramCe0(nVramCe0), .nVramCe1(nVramCe1),
        .nVramRd(nVramRd), .nVramWr(nVramWr), .vramRdData(vramRdData)
    );

    initial begin
        pixClk = 1'b0;
        forever begin
            #10 pixClk = ~pixClk;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error: %s = %0h, expected %0h at time %0t", name, got, exp, $time);
        errCount++;
    endtask

    task automatic endTest(input string name, input int startErrs);
        testCount++;
        if (errCount == startErrs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errCount - startErrs);
        end
    endtask

    // pixel expected on visible column x for byte b
    function automatic logic [3:0] expectedPixel(input logic [7:0] b, input int x,
                                                 input logic gray);
        logic [1:0] pair;
        pair = 2'(b >> (6 - 2 * (x % 4)));
        if (gray) begin
            return {pair[1], pair[1], pair[1], pair[0]};
        end
        // each nibble covers two columns
        if ((x % 4) < 2) begin
            return b[7:4];
        end
        return b[3:0];
    endfunction

    // step falling edges until the chosen sync output reaches level
    task automatic awaitLevel(input logic useV, input logic level, input int limit,
                              output int clks);
        clks = 0;
        while (((useV ? vidV : vidH) !== level) && (clks < limit)) begin
            @(negedge pixClk);
            clks++;
        end
        if ((useV ? vidV : vidH) !== level) begin
            $display("Error: %s did not reach %b within %0d clocks",
                     useV ? "vidV" : "vidH", level, limit);
            errCount++;
        end
    endtask

    // returns on the falling edge where vidH rises just before line 0
    task automatic seekFrameStart();
        int c;
        awaitLevel(1'b1, 1'b1, frameLimit, c);
        awaitLevel(1'b1, 1'b0, 2 * lineClks, c);
        for (int n = 0; n < vBackLines; n++) begin
            awaitLevel(1'b0, 1'b0, lineClks, c);
            awaitLevel(1'b0, 1'b1, lineClks, c);
        end
    endtask

    // one cpu bus cycle, held until the acknowledge shows up
    task automatic cpuCycle(input logic rnw, input logic [15:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
        int waitClks;
        @(negedge pixClk);
        nCpuCe = 1'b0;
        nCpuDs = 1'b0;
        cpuRnW = rnw;
        cpuAddr = addr;
        cpuWrData = wdata;
        rdata = 8'hxx;
        waitClks = 0;
        do begin
            @(negedge pixClk);
            waitClks++;
        end while ((nCpuDsAck !== 1'b0) && (waitClks < ackLimit));
        if (nCpuDsAck !== 1'b0) begin
            $display("Error: no acknowledge for address %h within %0d clocks", addr, ackLimit);
            errCount++;
        end else begin
            // read enable only comes with the acknowledge of a read
            if (cpuRdEn !== rnw) reportMismatch("cpuRdEn", cpuRdEn, rnw);
            rdata = cpuRdData;
        end
        nCpuDs = 1'b1;
        nCpuCe = 1'b1;
        // acknowledge is gated by the data strobe, so it drops right away
        #1;
        if (nCpuDsAck !== 1'b1) reportMismatch("nCpuDsAck", nCpuDsAck, 1);
        if (cpuRdEn !== 1'b0) reportMismatch("cpuRdEn", cpuRdEn, 0);
    endtask

    task automatic checkIdleOutputs();
        if (vidH !== 1'b1) reportMismatch("vidH", vidH, 1);
        if (vidV !== 1'b0) reportMismatch("vidV", vidV, 0);
        if (vidOut !== 4'h0) reportMismatch("vidOut", vidOut, 0);
        if (nCpuDsAck !== 1'b1) reportMismatch("nCpuDsAck", nCpuDsAck, 1);
        if (cpuRdEn !== 1'b0) reportMismatch("cpuRdEn", cpuRdEn, 0);
        if (nVramCe0 !== 1'b1) reportMismatch("nVramCe0", nVramCe0, 1);
        if (nVramCe1 !== 1'b1) reportMismatch("nVramCe1", nVramCe1, 1);
        if (nVramRd !== 1'b1) reportMismatch("nVramRd", nVramRd, 1);
        if (nVramWr !== 1'b1) reportMismatch("nVramWr", nVramWr, 1);
        if (vramDataOe !== 1'b0) reportMismatch("vramDataOe", vramDataOe, 0);
        if (DUT.blank !== 1'b0) reportMismatch("blank", DUT.blank, 0);
        if (DUT.grayMode !== 1'b0) reportMismatch("grayMode", DUT.grayMode, 0);
    endtask

    task automatic resetTest();
        int startErrs;
        startErrs = errCount;
        repeat (4) @(posedge pixClk);
        @(negedge pixClk);
        checkIdleOutputs();
        repeat (4) @(posedge pixClk);
        @(negedge pixClk);
        nReset = 1'b1;
        // still before the first active clock edge
        #1;
        checkIdleOutputs();
        endTest("reset", startErrs);
    endtask

    task automatic regTest();
        int startErrs;
        int c;
        logic [7:0] rd;
        startErrs = errCount;
        // still early in line 0, active video, so both status bits are clear
        cpuCycle(1'b0, ctrlAddr, 8'h09, rd);
        cpuCycle(1'b1, ctrlAddr, 8'h00, rd);
        if (rd !== 8'hCF) reportMismatch("cpuRdData", rd, 8'hCF);
        // blank and gray cleared, the other written ones are not stored
        cpuCycle(1'b0, ctrlAddr, 8'hF6, rd);
        // vsync lines are vertical blanking, start of line is still horizontal active
        awaitLevel(1'b1, 1'b1, frameLimit, c);
        cpuCycle(1'b1, ctrlAddr, 8'h00, rd);
        if (rd !== 8'hE6) reportMismatch("cpuRdData", rd, 8'hE6);
        // hsync pulse lies in horizontal blanking too
        awaitLevel(1'b0, 1'b0, lineClks, c);
        cpuCycle(1'b1, ctrlAddr, 8'h00, rd);
        if (rd !== 8'hF6) reportMismatch("cpuRdData", rd, 8'hF6);
        endTest("register", startErrs);
    endtask

    task automatic syncTest();
        int startErrs;
        int c;
        int lowClks;
        int highClks;
        int cyc;
        int vHigh;
        int falls;
        int fallsInSync;
        logic prevH;
        logic prevV;
        logic done;
        startErrs = errCount;
        awaitLevel(1'b0, 1'b1, lineClks, c);
        awaitLevel(1'b0, 1'b0, lineClks, c);
        awaitLevel(1'b0, 1'b1, lineClks, lowClks);
        awaitLevel(1'b0, 1'b0, lineClks, highClks);
        if (lowClks != hSyncClks) reportMismatch("vidH low clocks", lowClks, hSyncClks);
        if (lowClks + highClks != lineClks) begin
            reportMismatch("vidH period", lowClks + highClks, lineClks);
        end
        // one frame from a vidV rise to the next, lines counted by vidH falls
        awaitLevel(1'b1, 1'b0, frameLimit, c);
        awaitLevel(1'b1, 1'b1, frameLimit, c);
        vHigh = 1;
        falls = 0;
        fallsInSync = 0;
        cyc = 0;
        prevH = vidH;
        prevV = 1'b1;
        done = 1'b0;
        while (!done && (cyc < frameLimit)) begin
            @(negedge pixClk);
            cyc++;
            if (vidV && !prevV) begin
                done = 1'b1;
            end else begin
                if (vidV) vHigh++;
                if (prevH && !vidH) begin
                    falls++;
                    if (vidV) fallsInSync++;
                end
            end
            prevH = vidH;
            prevV = vidV;
        end
        if (!done) begin
            $display("Error: vidV did not rise again within %0d clocks", frameLimit);
            errCount++;
        end
        if (vHigh != vSyncLines * lineClks) begin
            reportMismatch("vidV high clocks", vHigh, vSyncLines * lineClks);
        end
        if (fallsInSync != vSyncLines) reportMismatch("vidV lines", fallsInSync, vSyncLines);
        if (falls != frameLines) reportMismatch("frame lines", falls, frameLines);
        endTest("sync timing", startErrs);
    endtask

    task automatic vramTest();
        int startErrs;
        logic [15:0] addrs [16];
        logic [7:0] data [16];
        logic [7:0] rd;
        logic [7:0] stored;
        startErrs = errCount;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 16'($urandom());
            // alternate chips, low nibble keeps addresses apart
            addrs[i][15] = i[0];
            addrs[i][3:0] = 4'(i);
            if (addrs[i] == ctrlAddr) addrs[i][4] = 1'b0;
            data[i] = 8'($urandom());
            cpuCycle(1'b0, addrs[i], data[i], rd);
        end
        @(negedge pixClk);
        for (int i = 0; i < 16; i++) begin
            stored = addrs[i][15] ? VRAM.chip1[addrs[i][14:0]] : VRAM.chip0[addrs[i][14:0]];
            if (stored !== data[i]) reportMismatch("vram array", stored, data[i]);
            cpuCycle(1'b1, addrs[i], 8'h00, rd);
            if (rd !== data[i]) reportMismatch("cpuRdData", rd, data[i]);
        end
        endTest("vram", startErrs);
    endtask

    task automatic pixelTest(input logic gray, input string name);
        int startErrs;
        logic [7:0] rd;
        logic [3:0] exp;
        startErrs = errCount;
        cpuCycle(1'b0, ctrlAddr, gray ? 8'h08 : 8'h00, rd);
        seekFrameStart();
        // the clock before column 0 is still outside the window
        repeat (hBackClks - 1) @(negedge pixClk);
        if (vidOut !== 4'h0) reportMismatch("vidOut", vidOut, 0);
        for (int x = 0; x < testCols; x++) begin
            @(negedge pixClk);
            exp = expectedPixel(frameBytes[x / 4], x, gray);
            if (vidOut !== exp) reportMismatch("vidOut", vidOut, exp);
        end
        endTest(name, startErrs);
    endtask

    task automatic blankTest();
        int startErrs;
        int c;
        int bad;
        logic [3:0] firstBad;
        logic [7:0] rd;
        startErrs = errCount;
        cpuCycle(1'b0, ctrlAddr, 8'h01, rd);
        // one full line period starting at the end of the current hsync
        awaitLevel(1'b0, 1'b0, lineClks, c);
        awaitLevel(1'b0, 1'b1, lineClks, c);
        bad = 0;
        firstBad = 4'h0;
        for (int s = 0; s < lineClks; s++) begin
            @(negedge pixClk);
            if (vidOut !== 4'h0) begin
                if (bad == 0) firstBad = vidOut;
                bad++;
            end
        end
        if (bad != 0) begin
            $display("** Error: vidOut = %h on %0d clocks of a blanked line, expected 0",
                     firstBad, bad);
            errCount++;
        end
        endTest("blank", startErrs);
    endtask

    initial begin
        seed = 32'h302d_8a71;
        void'($urandom(seed));
        nReset = 1'b0;
        nCpuCe = 1'b1;
        nCpuDs = 1'b1;
        cpuRnW = 1'b1;
        cpuAddr = 16'h0000;
        cpuWrData = 8'h00;
        resetTest();
        regTest();
        syncTest();
        vramTest();
        // start of the frame with known bytes
        for (int i = 0; i < 16; i++) begin
            frameBytes[i] = 8'($urandom());
            VRAM.chip0[i] = frameBytes[i];
        end
        pixelTest(1'b0, "4bpp pixels");
        pixelTest(1'b1, "gray pixels");
        blankTest();
        $display("tests run: %0d, errors: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/vramModel.sv
// behavioral model of two 32K x 8 VRAM chips with chip selects, read and write strobes
`default_nettype none

module vramModel (
    input  wire logic             pixClk,
    input  wire vidPkg::vramAddrT vramAddr,
    input  wire vidPkg::byteT     vramWrData,
    input  wire logic             vramDataOe,
    input  wire logic             nVramCe0,
    input  wire logic             nVramCe1,
    input  wire logic             nVramRd,
    input  wire logic             nVramWr,
    output vidPkg::byteT          vramRdData
);

    // chip 0 holds cpu addresses below 8000, chip 1 the upper half
    vidPkg::byteT chip0 [32768];
    vidPkg::byteT chip1 [32768];

    // power-up contents, each byte tied to its full address and its chip
    initial begin
        for (int a = 0; a < 32768; a++) begin
            chip0[a] = 8'(a) ^ {1'b0, 7'(a >> 8)};
            chip1[a] = 8'(a) ^ {1'b1, 7'(a >> 8)};
        end
    end

    // read data follows the address while a chip is selected with its read strobe low
    // the sequencer samples it on the next rising edge
    assign vramRdData = (!nVramRd && !nVramCe0) ? chip0[vramAddr] :
                        (!nVramRd && !nVramCe1) ? chip1[vramAddr] : 8'hxx;

    // write lands at the end of the clock with both write strobe and data enable active
    always @(posedge pixClk) begin
        if (!nVramWr && vramDataOe) begin
            if (!nVramCe0) begin
                chip0[vramAddr] <= vramWrData;
            end
            if (!nVramCe1) begin
                chip1[vramAddr] <= vramWrData;
            end
        end
    end

endmodule

`default_nettype wire
